/* src/qkv_pkg.sv */
// Sizes are fixed here; TIME_STEPS must not exceed TOKEN_DIM and index widths must cover the sizes
`default_nettype none

package qkv_pkg;

    // Token and element geometry
    localparam int TOKEN_DIM  = 8;
    localparam int ELEM_W     = 8;   // Element and weight, signed
    localparam int ELEM_IDX_W = 3;

    // Projection geometry
    localparam int OUT_CH   = 4;
    localparam int CH_IDX_W = 2;
    localparam int PSUM_W   = 20;    // Holds TOKEN_DIM full-scale products

    // Neuron stage
    localparam int TIME_STEPS    = 4;
    localparam int LIF_THRESHOLD = 128;
    localparam int MEMB_W        = PSUM_W + 2;  // Headroom for TIME_STEPS additions

    // Packed output line, query and key per step
    localparam int LINE_W = 2 * OUT_CH * TIME_STEPS;

    typedef enum logic {
        PROJ_Q = 1'b0,
        PROJ_K = 1'b1
    } proj_e;

    typedef enum logic {
        LIF_IDLE = 1'b0,
        LIF_RUN  = 1'b1
    } lif_state_e;

endpackage

`default_nettype wire

/* src/token_buffer.sv */
// At most one element per cycle, no back-pressure; a bank must be replayed before it refills
`timescale 1ns/1ps
`default_nettype none

module token_buffer (
    input  wire                                 s_clk,
    input  wire                                 i_reset,
    input  wire                                 i_data_valid,
    input  wire signed [qkv_pkg::ELEM_W-1:0]    i_fmap,
    input  wire signed [qkv_pkg::ELEM_W-1:0]    i_patchdata,
    output logic                                o_elem_valid,
    output logic signed [qkv_pkg::ELEM_W-1:0]   o_elem_data,
    output logic                                o_elem_last
);

    logic signed [qkv_pkg::ELEM_W:0]     raw_sum;
    logic signed [qkv_pkg::ELEM_W-1:0]   sat_sum;
    logic signed [qkv_pkg::ELEM_W-1:0]   bank_mem [2][qkv_pkg::TOKEN_DIM];
    logic [qkv_pkg::ELEM_IDX_W-1:0]      wr_idx;
    logic [qkv_pkg::ELEM_IDX_W-1:0]      rd_idx;
    logic                                wr_bank;
    logic                                rd_bank;
    logic                                rd_busy;
    logic                                wr_full;

    assign raw_sum = i_fmap + i_patchdata;  // One extra bit, no wrap

    // Clamp to the signed element range
    always_comb begin
        if (raw_sum[qkv_pkg::ELEM_W] != raw_sum[qkv_pkg::ELEM_W-1]) begin
            sat_sum = raw_sum[qkv_pkg::ELEM_W] ? {1'b1, {(qkv_pkg::ELEM_W-1){1'b0}}}
                                               : {1'b0, {(qkv_pkg::ELEM_W-1){1'b1}}};
        end else begin
            sat_sum = raw_sum[qkv_pkg::ELEM_W-1:0];
        end
    end

    assign wr_full = i_data_valid && (wr_idx == qkv_pkg::ELEM_IDX_W'(qkv_pkg::TOKEN_DIM - 1));

    always_ff @(posedge s_clk) begin
        if (i_data_valid) begin
            bank_mem[wr_bank][wr_idx] <= sat_sum;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            wr_idx  <= '0;
            wr_bank <= 1'b0;
            rd_idx  <= '0;
            rd_bank <= 1'b0;
            rd_busy <= 1'b0;
        end else begin
            if (i_data_valid) begin
                wr_idx <= wr_full ? '0 : wr_idx + 1'b1;
            end
            if (wr_full) begin
                // Full bank is ready, replay it and fill the other one
                wr_bank <= ~wr_bank;
                rd_bank <= wr_bank;
                rd_idx  <= '0;
                rd_busy <= 1'b1;
            end else if (rd_busy) begin
                if (o_elem_last) begin
                    rd_busy <= 1'b0;
                end
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    assign o_elem_valid = rd_busy;
    assign o_elem_data  = bank_mem[rd_bank][rd_idx];
    assign o_elem_last  = rd_busy && (rd_idx == qkv_pkg::ELEM_IDX_W'(qkv_pkg::TOKEN_DIM - 1));

endmodule

`default_nettype wire

/* src/proj_unit.sv */
// Weights must be stable while tokens are in flight; a new token may not finish before firing ends
`timescale 1ns/1ps
`default_nettype none

module proj_unit #(
    parameter qkv_pkg::proj_e PROJ = qkv_pkg::PROJ_Q
) (
    input  wire                                         s_clk,
    input  wire                                         i_reset,
    input  wire                                         i_w_we,
    input  wire qkv_pkg::proj_e                         i_w_proj,
    input  wire [qkv_pkg::CH_IDX_W-1:0]                 i_w_ch,
    input  wire [qkv_pkg::ELEM_IDX_W-1:0]               i_w_elem,
    input  wire signed [qkv_pkg::ELEM_W-1:0]            i_w_data,
    input  wire                                         i_elem_valid,
    input  wire signed [qkv_pkg::ELEM_W-1:0]            i_elem_data,
    input  wire                                         i_elem_last,
    output logic [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0] o_spikes,
    output logic                                        o_spikes_valid
);

    logic signed [qkv_pkg::ELEM_W-1:0]      weights [qkv_pkg::OUT_CH][qkv_pkg::TOKEN_DIM];
    logic [qkv_pkg::ELEM_IDX_W-1:0]         elem_idx;
    logic signed [2*qkv_pkg::ELEM_W-1:0]    prod     [qkv_pkg::OUT_CH];
    logic signed [qkv_pkg::PSUM_W-1:0]      acc      [qkv_pkg::OUT_CH];
    logic signed [qkv_pkg::PSUM_W-1:0]      acc_next [qkv_pkg::OUT_CH];
    logic signed [qkv_pkg::PSUM_W-1:0]      psum     [qkv_pkg::OUT_CH];
    logic signed [qkv_pkg::MEMB_W-1:0]      membrane [qkv_pkg::OUT_CH];
    logic signed [qkv_pkg::MEMB_W-1:0]      memb_sum [qkv_pkg::OUT_CH];
    logic [qkv_pkg::OUT_CH-1:0]             fire;
    qkv_pkg::lif_state_e                    lif_state;
    logic [qkv_pkg::ELEM_IDX_W-1:0]         step;
    logic                                   load;

    // Only writes addressed to this projection land here
    always_ff @(posedge s_clk) begin
        if (i_w_we && (i_w_proj == PROJ)) begin
            weights[i_w_ch][i_w_elem] <= i_w_data;
        end
    end

    always_comb begin
        for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
            prod[c]     = i_elem_data * weights[c][elem_idx];
            acc_next[c] = acc[c] + qkv_pkg::PSUM_W'(prod[c]);
        end
    end

    assign load = i_elem_valid && i_elem_last;

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            elem_idx <= '0;
            for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
                acc[c] <= '0;
            end
        end else if (i_elem_valid) begin
            elem_idx <= i_elem_last ? '0 : elem_idx + 1'b1;
            for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
                acc[c] <= i_elem_last ? '0 : acc_next[c];  // Clear for the next token
            end
        end
    end

    // Final sums include the last element directly
    always_ff @(posedge s_clk) begin
        if (load) begin
            for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
                psum[c] <= acc_next[c];
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            lif_state      <= qkv_pkg::LIF_IDLE;
            step           <= '0;
            o_spikes_valid <= 1'b0;
        end else begin
            o_spikes_valid <= 1'b0;
            if (load) begin
                lif_state <= qkv_pkg::LIF_RUN;
                step      <= '0;
            end else if (lif_state == qkv_pkg::LIF_RUN) begin
                if (step == qkv_pkg::ELEM_IDX_W'(qkv_pkg::TIME_STEPS - 1)) begin
                    lif_state      <= qkv_pkg::LIF_IDLE;
                    o_spikes_valid <= 1'b1;  // Last step's bits land on the same edge
                end
                step <= step + 1'b1;
            end
        end
    end

    // Integrate, fire at threshold, soft reset by subtraction
    always_comb begin
        for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
            memb_sum[c] = membrane[c] + qkv_pkg::MEMB_W'(psum[c]);
            fire[c]     = memb_sum[c] >= qkv_pkg::MEMB_W'(qkv_pkg::LIF_THRESHOLD);
        end
    end

    always_ff @(posedge s_clk) begin
        for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
            if (load) begin
                membrane[c] <= '0;
            end else if (lif_state == qkv_pkg::LIF_RUN) begin
                membrane[c] <= fire[c] ? memb_sum[c] - qkv_pkg::MEMB_W'(qkv_pkg::LIF_THRESHOLD)
                                       : memb_sum[c];
                o_spikes[int'(step) * qkv_pkg::OUT_CH + c] <= fire[c];
            end
        end
    end

endmodule

`default_nettype wire

/* src/spike_line_packer.sv */
// Expects one query and one key bus per token, each side at most once before the line leaves
`timescale 1ns/1ps
`default_nettype none

module spike_line_packer (
    input  wire                                             s_clk,
    input  wire                                             i_reset,
    input  wire [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0]   i_q_spikes,
    input  wire                                             i_q_valid,
    input  wire [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0]   i_k_spikes,
    input  wire                                             i_k_valid,
    output logic [qkv_pkg::LINE_W-1:0]                      o_spike_line,
    output logic                                            o_line_valid
);

    logic [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0] q_hold;
    logic [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0] k_hold;
    logic                                           q_have;
    logic                                           k_have;

    always_ff @(posedge s_clk) begin
        if (i_q_valid) begin
            q_hold <= i_q_spikes;
        end
        if (i_k_valid) begin
            k_hold <= i_k_spikes;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            q_have       <= 1'b0;
            k_have       <= 1'b0;
            o_line_valid <= 1'b0;
        end else begin
            o_line_valid <= q_have && k_have;
            if (q_have && k_have) begin
                q_have <= 1'b0;
                k_have <= 1'b0;
            end
            // A fresh bus wins over the clear
            if (i_q_valid) begin
                q_have <= 1'b1;
            end
            if (i_k_valid) begin
                k_have <= 1'b1;
            end
        end
    end

    // Per step: query channels low, key channels high
    always_ff @(posedge s_clk) begin
        if (q_have && k_have) begin
            for (int t = 0; t < qkv_pkg::TIME_STEPS; t++) begin
                for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
                    o_spike_line[t*2*qkv_pkg::OUT_CH + c] <= q_hold[t*qkv_pkg::OUT_CH + c];
                    o_spike_line[t*2*qkv_pkg::OUT_CH + qkv_pkg::OUT_CH + c] <=
                        k_hold[t*qkv_pkg::OUT_CH + c];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/qkv_linear_top.sv */
// Fixed latency of TOKEN_DIM + TIME_STEPS + 3 cycles per token; load weights before any token
`timescale 1ns/1ps
`default_nettype none

module qkv_linear_top (
    input  wire                                 s_clk,
    input  wire                                 i_reset,
    input  wire                                 i_data_valid,
    input  wire signed [qkv_pkg::ELEM_W-1:0]    i_fmap,
    input  wire signed [qkv_pkg::ELEM_W-1:0]    i_patchdata,
    input  wire                                 i_w_we,
    input  wire qkv_pkg::proj_e                 i_w_proj,
    input  wire [qkv_pkg::CH_IDX_W-1:0]         i_w_ch,
    input  wire [qkv_pkg::ELEM_IDX_W-1:0]       i_w_elem,
    input  wire signed [qkv_pkg::ELEM_W-1:0]    i_w_data,
    output wire [qkv_pkg::LINE_W-1:0]           o_spike_line,
    output wire                                 o_line_valid
);

    wire                                            elem_valid;
    wire signed [qkv_pkg::ELEM_W-1:0]               elem_data;
    wire                                            elem_last;
    wire [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0]  q_spikes;
    wire                                            q_spikes_valid;
    wire [qkv_pkg::OUT_CH*qkv_pkg::TIME_STEPS-1:0]  k_spikes;
    wire                                            k_spikes_valid;

    token_buffer u_token_buffer (
        .s_clk        (s_clk),
        .i_reset      (i_reset),
        .i_data_valid (i_data_valid),
        .i_fmap       (i_fmap),
        .i_patchdata  (i_patchdata),
        .o_elem_valid (elem_valid),
        .o_elem_data  (elem_data),
        .o_elem_last  (elem_last)
    );

    // Both units see the same replayed token
    proj_unit #(
        .PROJ (qkv_pkg::PROJ_Q)
    ) u_proj_q (
        .s_clk          (s_clk),
        .i_reset        (i_reset),
        .i_w_we         (i_w_we),
        .i_w_proj       (i_w_proj),
        .i_w_ch         (i_w_ch),
        .i_w_elem       (i_w_elem),
        .i_w_data       (i_w_data),
        .i_elem_valid   (elem_valid),
        .i_elem_data    (elem_data),
        .i_elem_last    (elem_last),
        .o_spikes       (q_spikes),
        .o_spikes_valid (q_spikes_valid)
    );

    proj_unit #(
        .PROJ (qkv_pkg::PROJ_K)
    ) u_proj_k (
        .s_clk          (s_clk),
        .i_reset        (i_reset),
        .i_w_we         (i_w_we),
        .i_w_proj       (i_w_proj),
        .i_w_ch         (i_w_ch),
        .i_w_elem       (i_w_elem),
        .i_w_data       (i_w_data),
        .i_elem_valid   (elem_valid),
        .i_elem_data    (elem_data),
        .i_elem_last    (elem_last),
        .o_spikes       (k_spikes),
        .o_spikes_valid (k_spikes_valid)
    );

    spike_line_packer u_packer (
        .s_clk        (s_clk),
        .i_reset      (i_reset),
        .i_q_spikes   (q_spikes),
        .i_q_valid    (q_spikes_valid),
        .i_k_spikes   (k_spikes),
        .i_k_valid    (k_spikes_valid),
        .o_spike_line (o_spike_line),
        .o_line_valid (o_line_valid)
    );

endmodule

`default_nettype wire

/* test/qkv_linear_chk.sv */
// Bound into qkv_linear_top; needs the internal q_spikes_valid and k_spikes_valid wires
`timescale 1ns/1ps
`default_nettype none

module qkv_linear_chk (
    input wire s_clk,
    input wire i_reset,
    input wire i_line_valid,
    input wire i_q_valid,
    input wire i_k_valid
);

    // No line while in reset or right after it
    assert property (@(posedge s_clk) i_reset |-> !i_line_valid)
        else $error("o_line_valid high during reset");

    assert property (@(posedge s_clk) i_reset |=> !i_line_valid)
        else $error("o_line_valid high in the cycle after reset");

    assert property (@(posedge s_clk) disable iff (i_reset) i_line_valid |=> !i_line_valid)
        else $error("o_line_valid high on two consecutive cycles");

    // Both projections finish firing together
    assert property (@(posedge s_clk) disable iff (i_reset) i_q_valid == i_k_valid)
        else $error("query and key spikes_valid strobes not aligned");

endmodule

bind qkv_linear_top qkv_linear_chk u_chk (
    .s_clk        (s_clk),
    .i_reset      (i_reset),
    .i_line_valid (o_line_valid),
    .i_q_valid    (q_spikes_valid),
    .i_k_valid    (k_spikes_valid)
);

`default_nettype wire

/* test/tb_qkv_linear.sv */
// Weights change only with no token in flight; the watchdog budget assumes NUM_TOKENS tokens
`timescale 1ns/1ps
`default_nettype none

module tb_qkv_linear;

    localparam int CLK_HALF     = 20;
    localparam int CLK_PERIOD   = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 3;
    localparam int TOKEN_LAT    = qkv_pkg::TOKEN_DIM + qkv_pkg::TIME_STEPS + 3;
    localparam int NUM_TOKENS   = 42;
    localparam int TIMEOUT_NS   = (NUM_TOKENS + 4) * TOKEN_LAT * CLK_PERIOD
                                  + RESET_CYCLES * CLK_PERIOD;
    localparam int HALF_W       = qkv_pkg::OUT_CH * qkv_pkg::TIME_STEPS;

    logic                                   s_clk;
    logic                                   i_reset;
    logic                                   i_data_valid;
    logic signed [qkv_pkg::ELEM_W-1:0]      i_fmap;
    logic signed [qkv_pkg::ELEM_W-1:0]      i_patchdata;
    logic                                   i_w_we;
    qkv_pkg::proj_e                         i_w_proj;
    logic [qkv_pkg::CH_IDX_W-1:0]           i_w_ch;
    logic [qkv_pkg::ELEM_IDX_W-1:0]         i_w_elem;
    logic signed [qkv_pkg::ELEM_W-1:0]      i_w_data;
    wire [qkv_pkg::LINE_W-1:0]              o_spike_line;
    wire                                    o_line_valid;

    int                         w_q [qkv_pkg::OUT_CH][qkv_pkg::TOKEN_DIM];  // Weight copies
    int                         w_k [qkv_pkg::OUT_CH][qkv_pkg::TOKEN_DIM];
    int                         tok_fmap  [qkv_pkg::TOKEN_DIM];
    int                         tok_patch [qkv_pkg::TOKEN_DIM];
    logic [qkv_pkg::LINE_W-1:0] expected_q [$];
    logic [qkv_pkg::LINE_W-1:0] last_line;
    integer                     seed;
    int                         mismatch_count = 0;
    int                         other_count = 0;
    int                         line_count = 0;
    bit                         check_q_zero = 1'b0;

    qkv_linear_top u_dut (
        .s_clk        (s_clk),
        .i_reset      (i_reset),
        .i_data_valid (i_data_valid),
        .i_fmap       (i_fmap),
        .i_patchdata  (i_patchdata),
        .i_w_we       (i_w_we),
        .i_w_proj     (i_w_proj),
        .i_w_ch       (i_w_ch),
        .i_w_elem     (i_w_elem),
        .i_w_data     (i_w_data),
        .o_spike_line (o_spike_line),
        .o_line_valid (o_line_valid)
    );

    always #CLK_HALF s_clk = ~s_clk;

    function automatic int clamp_elem(input int value);
        if (value > 127) return 127;
        if (value < -128) return -128;
        return value;
    endfunction

    // Saturated add, dot product, LIF with soft reset, then time-major packing
    function automatic logic [qkv_pkg::LINE_W-1:0] spike_line_ref(
        input int fm [qkv_pkg::TOKEN_DIM],
        input int pd [qkv_pkg::TOKEN_DIM]
    );
        logic [qkv_pkg::LINE_W-1:0] spk;
        int sum_q;
        int sum_k;
        int memb_q;
        int memb_k;
        int elem;
        spk = '0;
        for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
            sum_q = 0;
            sum_k = 0;
            for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
                elem  = clamp_elem(fm[e] + pd[e]);
                sum_q = sum_q + elem * w_q[c][e];
                sum_k = sum_k + elem * w_k[c][e];
            end
            memb_q = 0;
            memb_k = 0;
            for (int t = 0; t < qkv_pkg::TIME_STEPS; t++) begin
                memb_q = memb_q + sum_q;
                memb_k = memb_k + sum_k;
                if (memb_q >= qkv_pkg::LIF_THRESHOLD) begin
                    spk[t*2*qkv_pkg::OUT_CH + c] = 1'b1;
                    memb_q = memb_q - qkv_pkg::LIF_THRESHOLD;
                end
                if (memb_k >= qkv_pkg::LIF_THRESHOLD) begin
                    spk[t*2*qkv_pkg::OUT_CH + qkv_pkg::OUT_CH + c] = 1'b1;
                    memb_k = memb_k - qkv_pkg::LIF_THRESHOLD;
                end
            end
        end
        return spk;
    endfunction

    function automatic logic [HALF_W-1:0] query_part(input logic [qkv_pkg::LINE_W-1:0] spk);
        logic [HALF_W-1:0] bits;
        bits = '0;
        for (int t = 0; t < qkv_pkg::TIME_STEPS; t++) begin
            for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
                bits[t*qkv_pkg::OUT_CH + c] = spk[t*2*qkv_pkg::OUT_CH + c];
            end
        end
        return bits;
    endfunction

    task automatic write_weight(input qkv_pkg::proj_e proj, input int ch, input int elem,
                                input int value);
        @(negedge s_clk);
        i_data_valid = 1'b0;
        i_w_we       = 1'b1;
        i_w_proj     = proj;
        i_w_ch       = qkv_pkg::CH_IDX_W'(ch);
        i_w_elem     = qkv_pkg::ELEM_IDX_W'(elem);
        i_w_data     = qkv_pkg::ELEM_W'(value);
        if (proj == qkv_pkg::PROJ_Q) w_q[ch][elem] = value;
        else w_k[ch][elem] = value;
    endtask

    task automatic idle_cycle();
        @(negedge s_clk);
        i_w_we       = 1'b0;
        i_data_valid = 1'b0;
    endtask

    task automatic fill_weights(input int q_value, input int k_value);
        for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
            for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
                write_weight(qkv_pkg::PROJ_Q, c, e, q_value);
                write_weight(qkv_pkg::PROJ_K, c, e, k_value);
            end
        end
        idle_cycle();
    endtask

    task automatic random_weights();
        for (int c = 0; c < qkv_pkg::OUT_CH; c++) begin
            for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
                write_weight(qkv_pkg::PROJ_Q, c, e, $random(seed) % 8);
                write_weight(qkv_pkg::PROJ_K, c, e, $random(seed) % 8);
            end
        end
        idle_cycle();
    endtask

    task automatic set_random_token(input int span);
        for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
            tok_fmap[e]  = $random(seed) % span;
            tok_patch[e] = $random(seed) % span;
        end
    endtask

    // One strobe per cycle, expected line queued with the last element
    task automatic send_token();
        for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
            @(negedge s_clk);
            i_w_we       = 1'b0;
            i_data_valid = 1'b1;
            i_fmap       = qkv_pkg::ELEM_W'(tok_fmap[e]);
            i_patchdata  = qkv_pkg::ELEM_W'(tok_patch[e]);
        end
        expected_q.push_back(spike_line_ref(tok_fmap, tok_patch));
    endtask

    task automatic wait_drain();
        idle_cycle();
        while (expected_q.size() != 0) begin
            @(negedge s_clk);
        end
    endtask

    initial begin : compare_lines
        logic [qkv_pkg::LINE_W-1:0] expected;
        forever begin
            @(negedge s_clk);
            if (o_line_valid) begin
                line_count++;
                assert (expected_q.size() > 0) else begin
                    $display("ERROR at %0t: a line arrived with no token queued", $time);
                    other_count++;
                end
                if (expected_q.size() > 0) begin
                    expected = expected_q.pop_front();
                    assert (o_spike_line == expected) else begin
                        $display("CHECK FAILED time=%0t signal=o_spike_line expected=%h actual=%h",
                                 $time, expected, o_spike_line);
                        mismatch_count++;
                    end
                end
                if (check_q_zero) begin
                    assert (query_part(o_spike_line) == '0) else begin
                        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                                 $time, "o_spike_line query", {HALF_W{1'b0}},
                                 query_part(o_spike_line));
                        mismatch_count++;
                    end
                end
                last_line = o_spike_line;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("ERROR: run timed out after %0d ns with %0d lines still expected",
                 TIMEOUT_NS, expected_q.size());
        $display("Test FAILED");
        $finish;
    end

    initial begin : main_flow
        logic [qkv_pkg::LINE_W-1:0] line_before;
        seed         = 36488;
        s_clk        = 1'b0;
        i_reset      = 1'b1;
        i_data_valid = 1'b0;
        i_fmap       = '0;
        i_patchdata  = '0;
        i_w_we       = 1'b0;
        i_w_proj     = qkv_pkg::PROJ_Q;
        i_w_ch       = '0;
        i_w_elem     = '0;
        i_w_data     = '0;
        repeat (RESET_CYCLES) @(negedge s_clk);
        i_reset = 1'b0;

        // Unit weights, small positive token
        fill_weights(1, 1);
        for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
            tok_fmap[e]  = e + 1;
            tok_patch[e] = 1;
        end
        send_token();
        wait_drain();

        // Negative query sums never fire
        fill_weights(-1, 1);
        check_q_zero = 1'b1;
        for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
            tok_fmap[e]  = 10 + 3 * e;
            tok_patch[e] = 5;
        end
        send_token();
        wait_drain();
        check_q_zero = 1'b0;

        // Clamping above 127 and below -128
        for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
            tok_fmap[e]  = (e < 6) ? 120 : -128;
            tok_patch[e] = (e < 6) ? 100 : -50;
        end
        send_token();
        for (int n = 0; n < 7; n++) begin
            set_random_token(128);
            send_token();
        end
        wait_drain();

        // Back-to-back random tokens
        random_weights();
        for (int n = 0; n < 30; n++) begin
            set_random_token(40);
            send_token();
        end
        wait_drain();

        // A key write leaves the query half alone
        // Channel 1 only sees element 3, so flipping its key weight sign flips its spikes
        write_weight(qkv_pkg::PROJ_Q, 1, 3, -7);
        write_weight(qkv_pkg::PROJ_K, 1, 3, -7);
        idle_cycle();
        for (int e = 0; e < qkv_pkg::TOKEN_DIM; e++) begin
            tok_fmap[e]  = (e == 3) ? 100 : 0;
            tok_patch[e] = 0;
        end
        send_token();
        wait_drain();
        line_before = last_line;
        write_weight(qkv_pkg::PROJ_K, 1, 3, 7);
        idle_cycle();
        send_token();
        wait_drain();
        assert (query_part(last_line) == query_part(line_before)) else begin
            $display("CHECK FAILED time=%0t signal=o_spike_line query expected=%h actual=%h",
                     $time, query_part(line_before), query_part(last_line));
            mismatch_count++;
        end

        repeat (TOKEN_LAT) @(negedge s_clk);
        assert (expected_q.size() == 0) else begin
            $display("ERROR: %0d expected lines never arrived", expected_q.size());
            other_count++;
        end

        $display("Lines received %0d, value mismatches %0d, other errors %0d",
                 line_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/qkv_pkg.sv
src/token_buffer.sv
src/proj_unit.sv
src/spike_line_packer.sv
src/qkv_linear_top.sv
test/qkv_linear_chk.sv
test/tb_qkv_linear.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the qkv_linear testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
SIM_EXE=tb_qkv_linear_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_qkv_linear \
    -f sources.f \
    -o "$SIM_EXE"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$SIM_EXE" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG_FILE"; then
    echo "Simulation reported a failure, see $LOG_FILE"
    exit 1
fi

echo "Simulation passed"
exit 0
